/* hw/cmd_pkg.sv */
package cmd_pkg;

   // Source command format.
   localparam int OP_W  = 5;   // Bit 4 picks the local path.
   localparam int DST_W = 4;   // Register index or node id.
   localparam int DT_W  = 32;

   // Dispatched word is the opcode nibble over the destination.
   localparam int CMD_OP_W = 8;

   // Accepted-command counter, wraps.
   localparam int CNT_W = 4;

   // Local operation, taken from the low opcode nibble.
   typedef enum logic [3:0] {
      LOC_WR  = 4'd0,   // Register gets data.
      LOC_ADD = 4'd1,   // Register gets register plus data.
      LOC_XOR = 4'd2,   // Register gets register xor data.
      LOC_RD  = 4'd3    // Register is reported.
   } loc_op_e;

endpackage

/* hw/link_pkg.sv */
package link_pkg;

   // Ingress depth. The source owns this many credits at reset.
   localparam int DEF_FIFO_DEPTH = 4;

   // Buffer slots at the remote end of the link.
   localparam int DEF_LINK_CREDITS = 2;

   // Width of credit and occupancy counters.
   localparam int CRED_W = 3;

endpackage

/* hw/cmd_if.sv */
`timescale 1ns/1ps

interface cmd_if;
   import cmd_pkg::*;

   logic             vld;    // Queue holds a command.
   logic             take;   // Dispatcher takes the head.
   logic [OP_W-1:0]  op;
   logic [DST_W-1:0] dest;
   logic [DT_W-1:0]  dt;

   // Queue side.
   modport src (output vld, op, dest, dt, input take);

   // Dispatcher side.
   modport dst (input vld, op, dest, dt, output take);

endinterface

/* hw/cmd_ingress.sv */
`timescale 1ns/1ps

module cmd_ingress #(
   parameter int FIFO_DEPTH = link_pkg::DEF_FIFO_DEPTH
) (
   input  logic                      i_clk,
   input  logic                      i_rstn,
   input  logic                      src_vld_i,
   input  logic [cmd_pkg::OP_W-1:0]  src_op_i,
   input  logic [cmd_pkg::DST_W-1:0] src_dst_i,
   input  logic [cmd_pkg::DT_W-1:0]  src_dt_i,
   output logic                      src_credit_o,
   cmd_if.src                        cmd
);
   import cmd_pkg::*;
   import link_pkg::*;

   localparam int ENT_W = OP_W + DST_W + DT_W;
   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

   logic [ENT_W-1:0]  mem [FIFO_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CRED_W-1:0] count;
   logic [ENT_W-1:0]  head;

   // Storage, written on every source pulse.
   always_ff @(posedge i_clk) begin
      if (src_vld_i) begin
         mem[wr_ptr] <= {src_op_i, src_dst_i, src_dt_i};
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (src_vld_i) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (cmd.take) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   // Occupancy.
   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         count <= '0;
      end else begin
         case ({src_vld_i, cmd.take})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // One credit back per removal.
   always_ff @(posedge i_clk) begin
      if (!i_rstn) src_credit_o <= 1'b0;
      else         src_credit_o <= cmd.take;
   end

   assign head = mem[rd_ptr];
   assign cmd.vld = (count != '0);
   assign {cmd.op, cmd.dest, cmd.dt} = head;   // Head of queue.

   // A source that keeps to its credits never finds the queue full.
   a_no_overflow : assert property (@(posedge i_clk) disable iff (!i_rstn)
      src_vld_i |-> (count != CRED_W'(FIFO_DEPTH)));

endmodule

/* hw/ack_cmd.sv */
`timescale 1ns/1ps

module ack_cmd (
   input  logic                         i_clk,
   input  logic                         i_rstn,
   cmd_if.dst                           cmd,
   output logic                         loc_req_o,
   output logic                         net_req_o,
   input  logic                         async_ack_i,
   input  logic                         sync_ack_i,
   output logic [cmd_pkg::CMD_OP_W-1:0] cmd_op_o,
   output logic [cmd_pkg::DT_W-1:0]     cmd_dt_o,
   output logic [cmd_pkg::CNT_W-1:0]    cmd_cnt_do
);
   import cmd_pkg::*;

   // One-hot states.
   localparam logic [3:0] S_IDLE = 4'b0001;
   localparam logic [3:0] S_LOC  = 4'b0010;
   localparam logic [3:0] S_NET  = 4'b0100;
   localparam logic [3:0] S_ACK  = 4'b1000;

   logic [3:0]          state;
   logic [3:0]          state_nxt;
   logic                ack_meta;
   logic                ack_sync;
   logic                ack_s;
   logic [CMD_OP_W-1:0] cmd_op_s;
   logic [CMD_OP_W-1:0] cmd_op_r;
   logic [DT_W-1:0]     cmd_dt_r;
   logic [CNT_W-1:0]    cmd_cnt;

   // Remote acknowledge comes from another clock.
   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         ack_meta <= 1'b0;
         ack_sync <= 1'b0;
      end else begin
         ack_meta <= async_ack_i;
         ack_sync <= ack_meta;
      end
   end

   assign ack_s = sync_ack_i | ack_sync;

   always_ff @(posedge i_clk) begin
      if (!i_rstn) state <= S_IDLE;
      else         state <= state_nxt;
   end

   always_comb begin
      state_nxt = state;
      loc_req_o = 1'b0;
      net_req_o = 1'b0;
      case (state)
         S_IDLE: begin
            if (cmd.vld) begin
               if (cmd.op[OP_W-1]) begin   // Local executor.
                  state_nxt = S_LOC;
                  loc_req_o = 1'b1;
               end else begin
                  state_nxt = S_NET;
                  net_req_o = 1'b1;
               end
            end
         end
         S_LOC: begin
            loc_req_o = 1'b1;
            if (ack_s) state_nxt = S_ACK;
         end
         S_NET: begin
            net_req_o = 1'b1;
            if (ack_s) state_nxt = S_ACK;
         end
         S_ACK: begin
            if (!ack_s) state_nxt = S_IDLE;   // Wait for handshake to close.
         end
         default: state_nxt = S_IDLE;
      endcase
   end

   assign cmd.take = (state == S_IDLE) && cmd.vld;

   assign cmd_op_s = {cmd.op[OP_W-2:0], cmd.dest};

   // Held command word.
   always_ff @(posedge i_clk) begin
      if (cmd.take) begin
         cmd_op_r <= cmd_op_s;
         cmd_dt_r <= cmd.dt;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn)       cmd_cnt <= '0;
      else if (cmd.take) cmd_cnt <= cmd_cnt + 1'b1;
   end

   // Executors see the new word in the take cycle itself.
   assign cmd_op_o   = cmd.take ? cmd_op_s : cmd_op_r;
   assign cmd_dt_o   = cmd.take ? cmd.dt   : cmd_dt_r;
   assign cmd_cnt_do = cmd_cnt;

   // Only one executor acknowledges at a time.
   a_one_ack : assert property (@(posedge i_clk) disable iff (!i_rstn)
      !(sync_ack_i && ack_sync));

   // A new command is taken only once the last acknowledge has dropped.
   a_take_idle : assert property (@(posedge i_clk) disable iff (!i_rstn)
      cmd.take |-> !ack_s);

endmodule

/* hw/loc_exec.sv */
`timescale 1ns/1ps

module loc_exec (
   input  logic                         i_clk,
   input  logic                         i_rstn,
   input  logic                         loc_req_i,
   input  logic [cmd_pkg::CMD_OP_W-1:0] cmd_op_i,
   input  logic [cmd_pkg::DT_W-1:0]     cmd_dt_i,
   output logic                         sync_ack_o,
   output logic                         loc_rd_vld_o,
   output logic [cmd_pkg::DT_W-1:0]     loc_rd_data_o
);
   import cmd_pkg::*;

   logic [DT_W-1:0]  regs [2**DST_W];
   logic             req_q;
   logic             req_rise;
   loc_op_e          op;
   logic [DST_W-1:0] idx;

   assign op       = loc_op_e'(cmd_op_i[CMD_OP_W-1:DST_W]);
   assign idx      = cmd_op_i[DST_W-1:0];
   assign req_rise = loc_req_i && !req_q;

   // Register file.
   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         for (int i = 0; i < 2**DST_W; i++) begin
            regs[i] <= '0;
         end
      end else if (req_rise) begin
         case (op)
            LOC_WR:  regs[idx] <= cmd_dt_i;
            LOC_ADD: regs[idx] <= regs[idx] + cmd_dt_i;
            LOC_XOR: regs[idx] <= regs[idx] ^ cmd_dt_i;
            default: regs[idx] <= regs[idx];   // Read and unknown ops keep it.
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         req_q        <= 1'b0;
         sync_ack_o   <= 1'b0;
         loc_rd_vld_o <= 1'b0;
      end else begin
         req_q        <= loc_req_i;
         sync_ack_o   <= loc_req_i && (sync_ack_o || req_rise);   // Held until request drops.
         loc_rd_vld_o <= req_rise && (op == LOC_RD);
      end
   end

   always_ff @(posedge i_clk) begin
      if (req_rise && (op == LOC_RD)) loc_rd_data_o <= regs[idx];
   end

   // Dispatcher must see the acknowledge before it drops the request.
   a_req_held : assert property (@(posedge i_clk) disable iff (!i_rstn)
      $fell(loc_req_i) |-> sync_ack_o);

endmodule

/* hw/net_tx.sv */
`timescale 1ns/1ps

module net_tx #(
   parameter int LINK_CREDITS = link_pkg::DEF_LINK_CREDITS
) (
   input  logic                         i_clk,
   input  logic                         i_rstn,
   input  logic                         net_req_i,
   input  logic [cmd_pkg::CMD_OP_W-1:0] cmd_op_i,
   input  logic [cmd_pkg::DT_W-1:0]     cmd_dt_i,
   output logic                         net_vld_o,
   output logic [cmd_pkg::CMD_OP_W-1:0] net_op_o,
   output logic [cmd_pkg::DT_W-1:0]     net_dt_o,
   input  logic                         net_credit_i
);
   import link_pkg::*;

   logic [CRED_W-1:0] credits;
   logic              sent;
   logic              send;

   // One flit per request, only with a free remote slot.
   assign send = net_req_i && !sent && (credits != '0);

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         credits <= CRED_W'(LINK_CREDITS);
      end else begin
         case ({send, net_credit_i})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn)         sent <= 1'b0;
      else if (!net_req_i) sent <= 1'b0;   // Ready for the next command.
      else if (send)       sent <= 1'b1;
   end

   assign net_vld_o = send;
   assign net_op_o  = cmd_op_i;
   assign net_dt_o  = cmd_dt_i;

   // Remote peer never returns more than it was given.
   a_cred_max : assert property (@(posedge i_clk) disable iff (!i_rstn)
      credits <= CRED_W'(LINK_CREDITS));

endmodule

/* hw/cmd_top.sv */
`timescale 1ns/1ps

module cmd_top #(
   parameter int FIFO_DEPTH   = link_pkg::DEF_FIFO_DEPTH,
   parameter int LINK_CREDITS = link_pkg::DEF_LINK_CREDITS
) (
   input  logic                         i_clk,
   input  logic                         i_rstn,
   // Command source.
   input  logic                         src_vld_i,
   input  logic [cmd_pkg::OP_W-1:0]     src_op_i,
   input  logic [cmd_pkg::DST_W-1:0]    src_dst_i,
   input  logic [cmd_pkg::DT_W-1:0]     src_dt_i,
   output logic                         src_credit_o,
   // Network link.
   input  logic                         net_ack_i,   // Remote clock domain.
   input  logic                         net_credit_i,
   output logic                         net_vld_o,
   output logic [cmd_pkg::CMD_OP_W-1:0] net_op_o,
   output logic [cmd_pkg::DT_W-1:0]     net_dt_o,
   // Local read results.
   output logic                         loc_rd_vld_o,
   output logic [cmd_pkg::DT_W-1:0]     loc_rd_data_o,
   output logic [cmd_pkg::CNT_W-1:0]    cmd_cnt_o
);
   import cmd_pkg::*;

   logic                loc_req;
   logic                net_req;
   logic                sync_ack;
   logic [CMD_OP_W-1:0] cmd_op;
   logic [DT_W-1:0]     cmd_dt;

   cmd_if u_cmd_if ();

   cmd_ingress #(.FIFO_DEPTH(FIFO_DEPTH)) u_ingress (
      .i_clk        (i_clk),
      .i_rstn       (i_rstn),
      .src_vld_i    (src_vld_i),
      .src_op_i     (src_op_i),
      .src_dst_i    (src_dst_i),
      .src_dt_i     (src_dt_i),
      .src_credit_o (src_credit_o),
      .cmd          (u_cmd_if.src)
   );

   ack_cmd u_ack_cmd (
      .i_clk       (i_clk),
      .i_rstn      (i_rstn),
      .cmd         (u_cmd_if.dst),
      .loc_req_o   (loc_req),
      .net_req_o   (net_req),
      .async_ack_i (net_ack_i),
      .sync_ack_i  (sync_ack),
      .cmd_op_o    (cmd_op),
      .cmd_dt_o    (cmd_dt),
      .cmd_cnt_do  (cmd_cnt_o)
   );

   loc_exec u_loc_exec (
      .i_clk         (i_clk),
      .i_rstn        (i_rstn),
      .loc_req_i     (loc_req),
      .cmd_op_i      (cmd_op),
      .cmd_dt_i      (cmd_dt),
      .sync_ack_o    (sync_ack),
      .loc_rd_vld_o  (loc_rd_vld_o),
      .loc_rd_data_o (loc_rd_data_o)
   );

   net_tx #(.LINK_CREDITS(LINK_CREDITS)) u_net_tx (
      .i_clk        (i_clk),
      .i_rstn       (i_rstn),
      .net_req_i    (net_req),
      .cmd_op_i     (cmd_op),
      .cmd_dt_i     (cmd_dt),
      .net_vld_o    (net_vld_o),
      .net_op_o     (net_op_o),
      .net_dt_o     (net_dt_o),
      .net_credit_i (net_credit_i)
   );

endmodule

/* verif/cmd_tb.sv */
`timescale 1ns/1ps

module cmd_tb;
   import cmd_pkg::*;
   import link_pkg::*;

   localparam int FIFO_DEPTH   = DEF_FIFO_DEPTH;
   localparam int LINK_CREDITS = DEF_LINK_CREDITS;
   localparam int N_CMDS       = 300;
   localparam int N_SWEEP      = 16;             // Closing reads of every register.
   localparam int TIMEOUT_CYC  = N_CMDS * 60;
   localparam int SEED         = 32'h68e9ed69;
   localparam int STALL_FIRST  = 60;             // Flits with slow link credits.
   localparam int STALL_LAST   = 90;

   logic                i_clk;
   logic                i_rstn;
   logic                src_vld_i;
   logic [OP_W-1:0]     src_op_i;
   logic [DST_W-1:0]    src_dst_i;
   logic [DT_W-1:0]     src_dt_i;
   logic                src_credit_o;
   logic                net_ack_i;
   logic                net_credit_i;
   logic                net_vld_o;
   logic [CMD_OP_W-1:0] net_op_o;
   logic [DT_W-1:0]     net_dt_o;
   logic                loc_rd_vld_o;
   logic [DT_W-1:0]     loc_rd_data_o;
   logic [CNT_W-1:0]    cmd_cnt_o;

   integer seed = SEED;
   int     err_cnt = 0;
   bit     running = 1'b0;
   int     cyc = 0;

   // Source side.
   int sent = 0;
   int src_credits = FIFO_DEPTH;
   int min_credits = FIFO_DEPTH;

   // Remote peer.
   int flits = 0;
   int outstanding = 0;
   int ack_wait = -1;
   int ack_hold = 0;
   int cred_due[$];

   // Reference model, expected events in arrival order.
   logic [DT_W-1:0]     shadow [2**DST_W];
   bit                  exp_is_rd [$];
   logic [CMD_OP_W-1:0] exp_op [$];
   logic [DT_W-1:0]     exp_dt [$];

   cmd_top #(
      .FIFO_DEPTH   (FIFO_DEPTH),
      .LINK_CREDITS (LINK_CREDITS)
   ) u_dut (
      .i_clk         (i_clk),
      .i_rstn        (i_rstn),
      .src_vld_i     (src_vld_i),
      .src_op_i      (src_op_i),
      .src_dst_i     (src_dst_i),
      .src_dt_i      (src_dt_i),
      .src_credit_o  (src_credit_o),
      .net_ack_i     (net_ack_i),
      .net_credit_i  (net_credit_i),
      .net_vld_o     (net_vld_o),
      .net_op_o      (net_op_o),
      .net_dt_o      (net_dt_o),
      .loc_rd_vld_o  (loc_rd_vld_o),
      .loc_rd_data_o (loc_rd_data_o),
      .cmd_cnt_o     (cmd_cnt_o)
   );

   initial i_clk = 1'b0;
   always #4 i_clk = ~i_clk;   // 8 ns period.

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation stopped on error.");
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         err_cnt++;
         abort_run($sformatf("[ERROR] t=%0t %s got 0x%0h expected 0x%0h",
                             $time, name, got, exp));
      end
   endtask

   function automatic int rand_below(input int n);
      rand_below = $unsigned($random(seed)) % n;
   endfunction

   // Pick a command; the last reads sweep the whole register file.
   task automatic build_cmd(input int n, output logic [OP_W-1:0] op,
                            output logic [DST_W-1:0] dst, output logic [DT_W-1:0] dt);
      int k;
      dst = DST_W'(rand_below(2**DST_W));
      dt  = $random(seed);
      k   = rand_below(10);
      if (n >= N_CMDS - N_SWEEP) begin
         op  = {1'b1, LOC_RD};
         dst = DST_W'(n - (N_CMDS - N_SWEEP));
      end else if (k < 4) begin
         op = {1'b0, 4'(rand_below(16))};   // Network.
      end else if (k == 4) begin
         op = {1'b1, LOC_WR};
      end else if (k == 5) begin
         op = {1'b1, LOC_ADD};
      end else if (k == 6) begin
         op = {1'b1, LOC_XOR};
      end else if (k < 9) begin
         op = {1'b1, LOC_RD};
      end else begin
         op = {1'b1, 4'(4 + rand_below(12))};   // Undefined local op.
      end
   endtask

   // Commands run strictly in order, so the model applies them on arrival.
   task automatic model_cmd(input logic [OP_W-1:0] op, input logic [DST_W-1:0] dst,
                            input logic [DT_W-1:0] dt);
      if (!op[OP_W-1]) begin
         exp_is_rd.push_back(1'b0);
         exp_op.push_back({op[3:0], dst});
         exp_dt.push_back(dt);
      end else begin
         case (op[3:0])
            LOC_WR:  shadow[dst] = dt;
            LOC_ADD: shadow[dst] = shadow[dst] + dt;
            LOC_XOR: shadow[dst] = shadow[dst] ^ dt;
            LOC_RD: begin
               exp_is_rd.push_back(1'b1);
               exp_op.push_back('0);
               exp_dt.push_back(shadow[dst]);
            end
            default: ;   // No effect.
         endcase
      end
   endtask

   // Source and remote peer, both driven on the falling edge.
   always @(negedge i_clk) begin : drive_proc
      logic [OP_W-1:0]  op;
      logic [DST_W-1:0] dst;
      logic [DT_W-1:0]  dt;
      int               d;
      bit               found;
      cyc++;
      if (running) begin
         if (src_credit_o) begin
            if (src_credits >= FIFO_DEPTH) begin
               abort_run("Source got back more credits than it spent.");
            end
            src_credits++;
         end
         src_vld_i = 1'b0;
         if (sent < N_CMDS && src_credits > 0 && rand_below(4) != 0) begin
            build_cmd(sent, op, dst, dt);
            model_cmd(op, dst, dt);
            src_vld_i = 1'b1;
            src_op_i  = op;
            src_dst_i = dst;
            src_dt_i  = dt;
            src_credits--;
            sent++;
         end
         if (src_credits < min_credits) min_credits = src_credits;

         // Flit leaves at the next rising edge.
         if (net_vld_o) begin
            if (outstanding >= LINK_CREDITS) begin
               abort_run("Flit sent while all link credits were outstanding.");
            end
            outstanding++;
            if (flits >= STALL_FIRST && flits < STALL_LAST) d = 24 + rand_below(16);
            else                                           d = 1 + rand_below(8);
            cred_due.push_back(cyc + d);
            flits++;
            ack_wait = rand_below(6);
         end

         // One link credit back per cycle at most.
         net_credit_i = 1'b0;
         found = 1'b0;
         for (int k = 0; k < cred_due.size() && !found; k++) begin
            if (cred_due[k] <= cyc) begin
               cred_due.delete(k);
               net_credit_i = 1'b1;
               outstanding--;
               found = 1'b1;
            end
         end

         // Hold covers the two-flop synchronizer and the step to ACK.
         if (ack_hold > 0) begin
            ack_hold--;
            if (ack_hold == 0) net_ack_i = 1'b0;
         end
         if (ack_wait == 0) begin
            net_ack_i = 1'b1;
            ack_hold  = 4;
            ack_wait  = -1;
         end else if (ack_wait > 0) begin
            ack_wait--;
         end
      end
   end

   // Output monitor.
   always @(negedge i_clk) begin : mon_proc
      bit                  is_rd;
      logic [CMD_OP_W-1:0] op;
      logic [DT_W-1:0]     dt;
      if (running && net_vld_o) begin
         if (exp_is_rd.size() == 0) abort_run("Flit seen with no command waiting for one.");
         is_rd = exp_is_rd.pop_front();
         op    = exp_op.pop_front();
         dt    = exp_dt.pop_front();
         if (is_rd) abort_run("Flit seen where a register read was expected.");
         check_val("net_op_o", net_op_o, op);
         check_val("net_dt_o", net_dt_o, dt);
      end
      if (running && loc_rd_vld_o) begin
         if (exp_is_rd.size() == 0) abort_run("Register read seen with no read pending.");
         is_rd = exp_is_rd.pop_front();
         op    = exp_op.pop_front();
         dt    = exp_dt.pop_front();
         if (!is_rd) abort_run("Register read seen where a flit was expected.");
         check_val("loc_rd_data_o", loc_rd_data_o, dt);
      end
   end

   initial begin : watchdog
      repeat (TIMEOUT_CYC) @(posedge i_clk);
      abort_run("Timeout, the command stream did not drain in time.");
   end

   initial begin
      i_rstn       = 1'b0;
      src_vld_i    = 1'b0;
      src_op_i     = '0;
      src_dst_i    = '0;
      src_dt_i     = '0;
      net_ack_i    = 1'b0;
      net_credit_i = 1'b0;
      for (int i = 0; i < 2**DST_W; i++) begin
         shadow[i] = '0;
      end
      repeat (8) @(negedge i_clk);
      check_val("src_credit_o", src_credit_o, 0);
      check_val("net_vld_o", net_vld_o, 0);
      check_val("loc_rd_vld_o", loc_rd_vld_o, 0);
      i_rstn = 1'b1;
      @(posedge i_clk);
      running = 1'b1;

      // Wait for all commands, link credits and acknowledges to settle.
      while (!(sent == N_CMDS && exp_is_rd.size() == 0 &&
               cred_due.size() == 0 && ack_wait < 0 && ack_hold == 0)) begin
         @(posedge i_clk);
      end
      repeat (4) @(posedge i_clk);
      @(negedge i_clk);

      check_val("cmd_cnt_o", cmd_cnt_o, N_CMDS % (2**CNT_W));
      check_val("src_credits", src_credits, FIFO_DEPTH);
      check_val("src_credits_min", min_credits, 0);   // Queue filled during the stall.
      if (flits <= STALL_LAST) abort_run("Too few flits to cover the slow-credit stretch.");

      if (err_cnt == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         abort_run("Errors were found during the run.");
      end
   end

endmodule

/* files.f */
hw/cmd_pkg.sv
hw/link_pkg.sv
hw/cmd_if.sv
hw/cmd_ingress.sv
hw/ack_cmd.sv
hw/loc_exec.sv
hw/net_tx.sv
hw/cmd_top.sv
verif/cmd_tb.sv

/* Bender.yml */
package:
  name: cmd_dispatch

sources:
  - files:
      - hw/cmd_pkg.sv
      - hw/link_pkg.sv
      - hw/cmd_if.sv
      - hw/cmd_ingress.sv
      - hw/ack_cmd.sv
      - hw/loc_exec.sv
      - hw/net_tx.sv
      - hw/cmd_top.sv
  - target: test
    files:
      - verif/cmd_tb.sv
